/* all.f */
+incdir+hdl
hdl/snd_sample_pkg.sv
hdl/snd_timing_pkg.sv
hdl/snd_cen_gen.sv
hdl/snd_interpol6.sv
hdl/snd_sigma_delta.sv
hdl/snd_out_stage.sv
testbench/snd_out_stage_tb.sv

/* hdl/snd_cen_gen.sv */
// clock enable generator

`include "snd_config.svh"

module snd_cen_gen (
    input  logic                    clk,
    input  logic                    rst,
    output snd_timing_pkg::snd_en_t en
);
    import snd_timing_pkg::*;

    localparam int CLK_W = $clog2(`SND_CEN_DIV + 1);
    localparam int GRP_W = $clog2(CEN_PER_SYNTH);

    logic [CLK_W-1:0] clk_cnt;  // clocks within one cen period
    logic [GRP_W-1:0] cen_cnt;  // cens within one synth period
    logic             tick;     // last clock of a cen period

    assign tick = (clk_cnt == CLK_W'(`SND_CEN_DIV - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            clk_cnt <= '0;
            cen_cnt <= '0;
            en      <= '0;
        end else begin
            clk_cnt <= tick ? '0 : clk_cnt + 1'b1;
            if (tick) begin
                // wrap after the sixth cen
                cen_cnt <= (cen_cnt == GRP_W'(CEN_PER_SYNTH - 1)) ? '0 : cen_cnt + 1'b1;
            end
            en.cen    <= tick;  // registered, so the first one lands DIV clocks out
            en.clk_en <= tick && (cen_cnt == GRP_W'(CEN_PER_SYNTH - 1));
        end
    end

    // synth enable must coincide with a system enable
    a_clk_en_on_cen: assert property (@(posedge clk) disable iff (rst)
        en.clk_en |-> en.cen)
        else $error("clk_en without cen");

endmodule

/* hdl/snd_config.svh */
// sound output stage
// build-time constants

`ifndef SND_CONFIG_SVH
`define SND_CONFIG_SVH

// clk cycles per system enable
`define SND_CEN_DIV 4

// synthesizer sample width, one channel
`define SND_IN_W 12

// comb/integrator width, holds 6 x full input range
`define SND_FILTER_W 15

// interpolated sample width, filter width plus the x3 stage
`define SND_OUT_W 16

`endif

/* hdl/snd_interpol6.sv */
// comb/integrator interpolator, x6
// one channel, DC gain 18, wraps on overflow

`include "snd_config.svh"

module snd_interpol6 (
    input  logic                           clk,
    input  logic                           rst,
    input  snd_timing_pkg::snd_en_t        en,
    input  logic signed [`SND_IN_W-1:0]    snd_in,
    output logic signed [`SND_OUT_W-1:0]   snd_out
);
    localparam int IW = `SND_IN_W;
    localparam int FW = `SND_FILTER_W;
    localparam int OW = `SND_OUT_W;

    logic signed [IW-1:0] last;         // previous synth sample
    logic signed [FW-1:0] comb1;        // first difference
    logic signed [FW-1:0] last_comb1;
    logic signed [FW-1:0] comb2;        // second difference
    logic signed [FW-1:0] stuff;        // zero-stuffed comb2, cen rate
    logic signed [FW-1:0] integ1;
    logic signed [FW-1:0] integ2;

    // comb section at the synth rate
    always_ff @(posedge clk) begin
        if (rst) begin
            last       <= '0;
            comb1      <= '0;
            last_comb1 <= '0;
            comb2      <= '0;
        end else if (en.clk_en) begin
            last       <= snd_in;
            comb1      <= FW'(snd_in) - FW'(last);  // signed casts sign-extend
            last_comb1 <= comb1;
            comb2      <= comb1 - last_comb1;
        end
    end

    // upsample: one real value then five zeros
    always_ff @(posedge clk) begin
        if (rst) begin
            stuff <= '0;
        end else if (en.cen) begin
            stuff <= en.clk_en ? comb2 : '0;
        end
    end

    // integrators and output at the cen rate
    always_ff @(posedge clk) begin
        if (rst) begin
            integ1  <= '0;
            integ2  <= '0;
            snd_out <= '0;
        end else if (en.cen) begin
            integ1  <= integ1 + stuff;
            integ2  <= integ2 + integ1;
            // x3 as x2 + x1, filter already gives x6
            snd_out <= (OW'(integ2) <<< 1) + OW'(integ2);
        end
    end

    // a cen without clk_en must load a zero into the stuffing register
    a_zero_stuff: assert property (@(posedge clk) disable iff (rst)
        (en.cen && !en.clk_en) |=> (stuff == '0))
        else $error("zero-stuffing register not cleared");

endmodule

/* hdl/snd_out_stage.sv */
// sound output stage top
// enable generator and two interpolator/modulator lanes

`include "snd_config.svh"

module snd_out_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  snd_sample_pkg::synth_pair_t synth_in,
    output logic                        synth_req,
    output snd_sample_pkg::out_pair_t   snd_out,
    output logic                        pdm_left,
    output logic                        pdm_right
);
    import snd_timing_pkg::*;

    snd_en_t en;    // shared strobes for both lanes

    snd_cen_gen u_cen (
        .clk (clk),
        .rst (rst),
        .en  (en)
    );

    assign synth_req = en.clk_en;  // next sample wanted

    // left lane
    snd_interpol6 u_interp_l (
        .clk     (clk),
        .rst     (rst),
        .en      (en),
        .snd_in  (synth_in.left),
        .snd_out (snd_out.left)
    );

    snd_sigma_delta u_sd_l (
        .clk    (clk),
        .rst    (rst),
        .en     (en),
        .sample (snd_out.left),
        .pdm    (pdm_left)
    );

    // right lane
    snd_interpol6 u_interp_r (
        .clk     (clk),
        .rst     (rst),
        .en      (en),
        .snd_in  (synth_in.right),
        .snd_out (snd_out.right)
    );

    snd_sigma_delta u_sd_r (
        .clk    (clk),
        .rst    (rst),
        .en     (en),
        .sample (snd_out.right),
        .pdm    (pdm_right)
    );

endmodule

/* hdl/snd_sample_pkg.sv */
// stereo sample types

package snd_sample_pkg;

`include "snd_config.svh"

    // one synth-rate sample pair, valid on clk_en
    typedef struct packed {
        logic signed [`SND_IN_W-1:0] left;
        logic signed [`SND_IN_W-1:0] right;
    } synth_pair_t;

    // interpolated pair, valid on every cen
    typedef struct packed {
        logic signed [`SND_OUT_W-1:0] left;
        logic signed [`SND_OUT_W-1:0] right;
    } out_pair_t;

endpackage

/* hdl/snd_sigma_delta.sv */
// first-order sigma-delta modulator

`include "snd_config.svh"

module snd_sigma_delta (
    input  logic                           clk,
    input  logic                           rst,
    input  snd_timing_pkg::snd_en_t        en,
    input  logic signed [`SND_OUT_W-1:0]   sample,
    output logic                           pdm
);
    localparam int OW = `SND_OUT_W;

    logic [OW-1:0] offset;  // offset binary, 0 is full negative
    logic [OW-1:0] acc;     // error accumulator
    logic [OW:0]   sum;     // carry on top

    // flipping the sign bit adds half scale
    assign offset = {~sample[OW-1], sample[OW-2:0]};
    assign sum    = {1'b0, acc} + {1'b0, offset};

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
            pdm <= 1'b0;
        end else if (en.cen) begin
            acc <= sum[OW-1:0];
            pdm <= sum[OW];     // overflow is the output bit
        end
    end

    // output only moves on a cen edge
    a_pdm_hold: assert property (@(posedge clk) disable iff (rst)
        !en.cen |=> $stable(pdm))
        else $error("pdm changed without cen");

endmodule

/* hdl/snd_timing_pkg.sv */
// timing strobe types

package snd_timing_pkg;

`include "snd_config.svh"

    // cens per synthesizer sample, also the interpolation factor
    localparam int CEN_PER_SYNTH = 6;

    // both strobes are single-clk pulses, clk_en only together with cen
    typedef struct packed {
        logic cen;      // system enable, every SND_CEN_DIV clocks
        logic clk_en;   // synth enable, every sixth cen
    } snd_en_t;

endpackage

/* testbench/snd_out_stage_tb.sv */
// output stage testbench
// table rows held for ten synth periods, both lanes checked on every cen

`include "snd_config.svh"

module snd_out_stage_tb;
    import snd_sample_pkg::*;

    localparam int CENS_PER_SYNTH = 6;                      // interpolation factor
    localparam int SYNTH_PER_ROW  = 10;                     // synth periods per row
    localparam int CENS_PER_ROW   = SYNTH_PER_ROW * CENS_PER_SYNTH;
    localparam int SETTLE_CENS    = 4 * CENS_PER_SYNTH;     // four synth periods
    localparam int REQ_PERIOD     = CENS_PER_SYNTH * `SND_CEN_DIV;
    localparam int GAIN           = 18;                     // interpolator DC gain
    localparam int IN_MAX         = 1820;                   // largest legal magnitude
    localparam int ROWS           = 10;
    localparam int RESET_CYCLES   = 3;
    localparam int PDM_FULL       = 65536;                  // modulator full scale
    localparam int PDM_HALF       = 32768;
    localparam int TIMEOUT_CYCLES = ROWS * SYNTH_PER_ROW * REQ_PERIOD * 3 / 2 + RESET_CYCLES;

    logic        clk;
    logic        rst;
    synth_pair_t synth_in;
    logic        synth_req;
    out_pair_t   snd_out;
    logic        pdm_left;
    logic        pdm_right;

    // stimulus table
    int    row_l    [ROWS];
    int    row_r    [ROWS];
    string row_name [ROWS];

    int   err_value;        // wrong output sample
    int   err_monotonic;    // output moved away from its target
    int   err_timing;       // strobe spacing or idle levels
    int   err_pdm;          // pulse density out of bound
    int   cycles;           // clocks since start, for the timeout
    int   req_gap;          // clocks since last synth_req
    logic rst_q = 1'b1;     // rst as seen at the last posedge

    int prev_l;
    int prev_r;
    int ones_l;
    int ones_r;

    snd_out_stage u_snd_out_stage (
        .clk       (clk),
        .rst       (rst),
        .synth_in  (synth_in),
        .synth_req (synth_req),
        .snd_out   (snd_out),
        .pdm_left  (pdm_left),
        .pdm_right (pdm_right)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // five fixed rows, four random ones, one more fixed at the end
    task automatic fill_table();
        int i;
        row_l[0]    = 0;
        row_r[0]    = 0;
        row_name[0] = "zero";
        row_l[1]    = IN_MAX;
        row_r[1]    = IN_MAX;
        row_name[1] = "full_pos";
        row_l[2]    = -IN_MAX;
        row_r[2]    = -IN_MAX;
        row_name[2] = "full_neg";
        row_l[3]    = IN_MAX;               // full swing on the left lane
        row_r[3]    = -IN_MAX;
        row_name[3] = "opposite";
        row_l[4]    = 613;
        row_r[4]    = 613;
        row_name[4] = "equal_pair";
        for (i = 5; i < 9; i++) begin
            row_l[i]    = int'($urandom % (2 * IN_MAX + 1)) - IN_MAX;
            row_r[i]    = int'($urandom % (2 * IN_MAX + 1)) - IN_MAX;
            row_name[i] = $sformatf("random_%0d", i - 5);
        end
        row_l[9]    = -IN_MAX;
        row_r[9]    = IN_MAX;
        row_name[9] = "opposite_swap";
    endtask

    // true when cur lies between the last sample and the target
    function automatic bit stays_between(input int prev, input int cur, input int target);
        if (prev <= target) begin
            return (cur >= prev) && (cur <= target);
        end
        return (cur <= prev) && (cur >= target);
    endfunction

    // outputs while and right after reset
    task automatic check_idle(input string tag);
        if (snd_out.left !== '0) begin
            $display("MISMATCH %s_left: expected 0, actual %0d", tag, snd_out.left);
            err_value++;
        end
        if (snd_out.right !== '0) begin
            $display("MISMATCH %s_right: expected 0, actual %0d", tag, snd_out.right);
            err_value++;
        end
        if (pdm_left !== 1'b0 || pdm_right !== 1'b0) begin
            $display("MISMATCH %s_pdm: expected 00, actual %b%b", tag, pdm_left, pdm_right);
            err_timing++;
        end
        if (synth_req !== 1'b0) begin
            $display("MISMATCH %s_synth_req: expected 0, actual %b", tag, synth_req);
            err_timing++;
        end
    endtask

    // one lane on one cen
    task automatic check_lane(input string tag, input int target, input int act,
                              input int prev, input int c);
        if (!stays_between(prev, act, target)) begin
            $display("MISMATCH %s: expected %0d..%0d on cen %0d, actual %0d",
                     tag, prev, target, c, act);
            err_monotonic++;
        end
        if (c >= SETTLE_CENS && act != target) begin    // settled part of the row
            $display("MISMATCH %s: expected %0d on cen %0d, actual %0d",
                     tag, target, c, act);
            err_value++;
        end
    endtask

    // ones over the settled cens, within one pulse of the ideal density
    task automatic check_density(input string tag, input int x, input int ones);
        int n;
        int ideal;
        int scaled;
        n      = CENS_PER_ROW - SETTLE_CENS;
        ideal  = n * (GAIN * x + PDM_HALF);     // in 1/65536 of a pulse
        scaled = ones * PDM_FULL;
        if (scaled - ideal > PDM_FULL || ideal - scaled > PDM_FULL) begin
            $display("MISMATCH %s: expected %0d +/- 1 ones in %0d cens, actual %0d",
                     tag, (ideal + PDM_HALF) / PDM_FULL, n, ones);
            err_pdm++;
        end
    endtask

    task automatic wait_for_request();
        do begin
            @(negedge clk);
        end while (!synth_req);
    endtask

    task automatic report_counts();
        $display("errors: value %0d, monotonic %0d, timing %0d, density %0d",
                 err_value, err_monotonic, err_timing, err_pdm);
    endtask

    // synth_req spacing in clocks, the first pulse counted from reset release
    always @(posedge clk) begin
        rst_q <= rst;
    end

    always @(negedge clk) begin
        if (rst_q) begin
            req_gap = 0;
        end else begin
            req_gap = req_gap + 1;
            if (synth_req) begin
                if (req_gap != REQ_PERIOD) begin   // also catches a pulse two clocks long
                    $display("MISMATCH synth_req_spacing: expected %0d, actual %0d",
                             REQ_PERIOD, req_gap);
                    err_timing++;
                end
                req_gap = 0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the test did not finish within %0d clock cycles", cycles);
            report_counts();
            $display("Test failed");
            $finish;
        end
    end

    initial begin : main_seq
        int r;
        int c;
        int act_l;
        int act_r;
        int unsigned seed_init;
        rst       = 1'b1;
        synth_in  = '0;
        seed_init = $urandom(32'h847c_bc46);
        fill_table();

        repeat (RESET_CYCLES) @(negedge clk);
        check_idle("reset");
        rst = 1'b0;
        repeat (`SND_CEN_DIV) begin         // no request in the first cen period
            @(negedge clk);
            check_idle("after_reset");
        end

        for (r = 0; r < ROWS; r++) begin
            wait_for_request();
            synth_in.left  = row_l[r][`SND_IN_W-1:0];   // taken on this clk_en edge
            synth_in.right = row_r[r][`SND_IN_W-1:0];
            ones_l = 0;
            ones_r = 0;
            for (c = 0; c < CENS_PER_ROW; c++) begin
                if (c == 0) begin
                    @(negedge clk);
                end else begin
                    repeat (`SND_CEN_DIV) @(negedge clk);
                end
                act_l = snd_out.left;
                act_r = snd_out.right;
                check_lane({row_name[r], "_left"}, GAIN * row_l[r], act_l, prev_l, c);
                check_lane({row_name[r], "_right"}, GAIN * row_r[r], act_r, prev_r, c);
                prev_l = act_l;
                prev_r = act_r;
                if (c >= SETTLE_CENS) begin     // modulator input constant from here
                    ones_l += pdm_left;
                    ones_r += pdm_right;
                end
            end
            check_density({row_name[r], "_pdm_left"}, row_l[r], ones_l);
            check_density({row_name[r], "_pdm_right"}, row_r[r], ones_r);
        end

        report_counts();
        if (err_value + err_monotonic + err_timing + err_pdm == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
